// File: src.f
hdl/merge_pkg.sv
hdl/b_fifo.sv
hdl/rr_arbiter.sv
hdl/merge_top.sv
test/merge_checker.sv
test/merge_tb.sv

// File: Makefile
TOP = merge_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		--top-module $(TOP) -f src.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
		echo "Simulation reported errors"; exit 1; \
	fi
	@grep -q "Test OK" sim.log || { echo "Simulation did not finish"; exit 1; }

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps --top-module merge_top \
		hdl/merge_pkg.sv hdl/b_fifo.sv hdl/rr_arbiter.sv hdl/merge_top.sv

clean:
	rm -rf obj_dir sim.log

// File: test/merge_tb.sv
`timescale 1ns/10ps

module merge_tb
   import merge_pkg::*;
();

   localparam int IN_DEPTH  = 8;
   localparam int OUT_DEPTH = 16;
   localparam int WW        = $bits(word_t);
   localparam int LAT_CH    = 2;
   localparam int N_PLAIN   = 200;
   localparam int N_MIXED   = 300;
   // Latency word, rotation load, one full fill, then both random runs
   localparam int PLANNED    = 1 + 4 * NUM_CH + NUM_CH * IN_DEPTH + OUT_DEPTH + N_PLAIN + N_MIXED;
   localparam int MAX_CYCLES = 20 * PLANNED + 1000;

   logic                 clk;
   logic                 rst;
   logic [NUM_CH-1:0]    wr_valid;
   logic [NUM_CH-1:0]    wr_ready;
   logic [NUM_CH*WW-1:0] wr_data;
   logic                 read_valid;
   logic                 read_ready;
   tagged_t              out_data;

   logic check_rot;
   logic check_lat;
   logic check_full;
   logic check_end;
   int   error_count;

   int accepted = 0;                  // Words taken by the channel FIFOs
   int popped   = 0;
   int issued   = 0;                  // Write strobes raised so far
   int wr_limit = 0;

   merge_top #(
      .IN_DEPTH  (IN_DEPTH),
      .OUT_DEPTH (OUT_DEPTH)
   ) uut (
      .clk        (clk),
      .rst        (rst),
      .wr_valid   (wr_valid),
      .wr_ready   (wr_ready),
      .wr_data    (wr_data),
      .read_valid (read_valid),
      .read_ready (read_ready),
      .out_data   (out_data)
   );

   merge_checker #(
      .IN_DEPTH  (IN_DEPTH),
      .OUT_DEPTH (OUT_DEPTH)
   ) chk (
      .clk         (clk),
      .rst         (rst),
      .wr_valid    (wr_valid),
      .wr_ready    (wr_ready),
      .wr_data     (wr_data),
      .read_valid  (read_valid),
      .read_ready  (read_ready),
      .out_data    (out_data),
      .check_rot   (check_rot),
      .check_lat   (check_lat),
      .check_full  (check_full),
      .check_end   (check_end),
      .error_count (error_count)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [NUM_CH*WW-1:0] random_lanes();
      logic [NUM_CH*WW-1:0] d;
      for (int c = 0; c < NUM_CH; c++) begin
         d[c*WW +: WW] = $urandom;
      end
      return d;
   endfunction

   task automatic tally();
      @(posedge clk);
      accepted += $countones(wr_valid & wr_ready);
      if (read_valid && read_ready) begin
         popped++;
      end
   endtask

   // Never two strobes in a row, so a ready sampled at this edge still holds
   task automatic step(input int wr_pct, input int rd_pct);
      logic [NUM_CH-1:0] next_valid;
      tally();
      next_valid = '0;
      for (int c = 0; c < NUM_CH; c++) begin
         if (!wr_valid[c] && wr_ready[c] && issued < wr_limit &&
             ($urandom % 100) < wr_pct) begin
            next_valid[c] = 1'b1;
            issued++;
         end
      end
      wr_valid   <= next_valid;
      wr_data    <= random_lanes();
      read_valid <= !read_valid && read_ready && (($urandom % 100) < rd_pct);
   endtask

   task automatic reset_dut();
      @(posedge clk);
      rst        <= 1'b1;
      wr_valid   <= '0;
      read_valid <= 1'b0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
   endtask

   task automatic drain_and_close();
      while (popped < accepted || wr_valid != '0) begin
         step(0, 100);
      end
      step(0, 0);                     // Last word gets compared here
      check_end <= 1'b1;
      step(0, 0);
      check_end <= 1'b0;
   endtask

   initial begin
      int full_edges;
      void'($urandom(32'h9f37c1c7));
      rst        = 1'b1;
      wr_valid   = '0;
      wr_data    = '0;
      read_valid = 1'b0;
      check_rot  = 1'b0;
      check_lat  = 1'b0;
      check_full = 1'b0;
      check_end  = 1'b0;

      reset_dut();
      tally();
      wr_valid  <= NUM_CH'(1) << LAT_CH;
      wr_data   <= random_lanes();
      check_lat <= 1'b1;
      issued++;
      tally();
      wr_valid <= '0;
      drain_and_close();
      check_lat <= 1'b0;

      reset_dut();                    // Rotation needs the pointer at channel 0
      check_rot <= 1'b1;
      repeat (4) begin
         tally();
         wr_valid <= '1;
         wr_data  <= random_lanes();
         issued += NUM_CH;
      end
      tally();
      wr_valid <= '0;
      drain_and_close();
      check_rot <= 1'b0;

      wr_limit = issued + 1000;
      full_edges = 0;
      while (full_edges < 4) begin    // Consumer stalled until every channel is full
         step(70, 0);
         full_edges = (wr_ready == '0) ? full_edges + 1 : 0;
      end
      check_full <= 1'b1;
      step(0, 0);
      check_full <= 1'b0;
      drain_and_close();

      wr_limit = issued + N_PLAIN;
      while (issued < wr_limit) begin
         step(50, 100);
      end
      drain_and_close();

      wr_limit = issued + N_MIXED;
      while (issued < wr_limit) begin
         step(60, 40);
      end
      drain_and_close();

      repeat (2) @(posedge clk);
      $display("Errors: %0d", error_count);
      if (error_count == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      repeat (MAX_CYCLES) @(posedge clk);
      $display("Timeout after %0d cycles, words stopped coming out", MAX_CYCLES);
      $display("Errors: %0d", error_count);
      $display("Test FAILED");
      $finish;
   end

endmodule

// File: test/merge_checker.sv
`timescale 1ns/10ps

module merge_checker
   import merge_pkg::*;
#(
   parameter int IN_DEPTH  = 8,
   parameter int OUT_DEPTH = 16
) (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [NUM_CH-1:0]               wr_valid,
   input  logic [NUM_CH-1:0]               wr_ready,
   input  logic [NUM_CH*$bits(word_t)-1:0] wr_data,
   input  logic                            read_valid,
   input  logic                            read_ready,
   input  tagged_t                         out_data,
   input  logic                            check_rot,    // Tags must rotate 0,1,2,3
   input  logic                            check_lat,    // Measure idle latency of next write
   input  logic                            check_full,   // Design should be filled up
   input  logic                            check_end,    // All words should be out
   output int                              error_count
);

   localparam int TW = $bits(chan_t);
   localparam int WW = $bits(word_t);
   // read_ready rises two cycles after the accepting edge, so it is first seen on the third
   localparam int LAT_EDGES = 3;

   word_t ref_q [NUM_CH][$];          // Accepted words not yet seen on out_data
   int    errors = 0;
   logic  cmp_pending;
   logic  rst_q;
   int    rot_next;
   logic  lat_run;
   int    lat_edges;

   assign error_count = errors;

   // Expected tagged word for the tag that came out
   function automatic tagged_t expected_word(input tagged_t seen);
      int ch;
      ch = int'(seen[TW+WW-1 -: TW]);
      return {seen[TW+WW-1 -: TW], ref_q[ch][0]};
   endfunction

   always @(posedge clk) begin
      int      ch;
      int      held;
      tagged_t exp_word;
      rst_q <= rst;
      if (rst) begin
         cmp_pending <= 1'b0;
         rot_next    <= 0;
         lat_run     <= 1'b0;
         lat_edges   <= 0;
      end else begin
         if (rst_q) begin                                  // First edge after reset
            if (read_ready !== 1'b0) begin
               errors++;
               $display("[FAIL] %0t read_ready expected 0 actual %b", $time, read_ready);
            end
            if (wr_ready !== '1) begin
               errors++;
               $display("[FAIL] %0t wr_ready expected %h actual %h", $time,
                        {NUM_CH{1'b1}}, wr_ready);
            end
         end

         if ((wr_valid & ~wr_ready) != '0) begin
            errors++;
            $display("%0t: a producer wrote into a full channel FIFO", $time);
         end
         if (read_valid && !read_ready) begin
            errors++;
            $display("%0t: the consumer popped an empty output FIFO", $time);
         end

         if (cmp_pending) begin                            // Word popped on the last edge
            ch = int'(out_data[TW+WW-1 -: TW]);
            if (ref_q[ch].size() == 0) begin
               errors++;
               $display("%0t: out_data carries channel %0d, which has nothing pending",
                        $time, ch);
            end else begin
               exp_word = expected_word(out_data);
               if (out_data !== exp_word) begin
                  errors++;
                  $display("[FAIL] %0t out_data expected %h actual %h",
                           $time, exp_word, out_data);
               end
               void'(ref_q[ch].pop_front());
            end
            if (check_rot) begin
               if (ch != rot_next) begin
                  errors++;
                  $display("[FAIL] %0t out_data tag expected %0d actual %0d",
                           $time, rot_next, ch);
               end
               rot_next <= (rot_next + 1) % NUM_CH;
            end
         end
         cmp_pending <= read_valid && read_ready;

         for (int c = 0; c < NUM_CH; c++) begin
            if (wr_valid[c] && wr_ready[c]) begin
               ref_q[c].push_back(wr_data[c*WW +: WW]);
            end
         end

         if (lat_run) begin
            if (read_ready) begin
               lat_run <= 1'b0;
               if (lat_edges + 1 != LAT_EDGES) begin
                  errors++;
                  $display("[FAIL] %0t read_ready rise edge expected %0d actual %0d",
                           $time, LAT_EDGES, lat_edges + 1);
               end
            end else if (lat_edges + 1 > 4 * LAT_EDGES) begin
               lat_run <= 1'b0;
               errors++;
               $display("%0t: read_ready never rose after a write to an idle design", $time);
            end
            lat_edges <= lat_edges + 1;
         end else if (check_lat && (wr_valid & wr_ready) != '0) begin
            lat_run   <= 1'b1;
            lat_edges <= 0;
         end

         if (check_full) begin
            held = 0;
            for (int c = 0; c < NUM_CH; c++) begin
               held += ref_q[c].size();
            end
            if (held != NUM_CH * IN_DEPTH + OUT_DEPTH) begin
               errors++;
               $display("[FAIL] %0t accepted words expected %0d actual %0d",
                        $time, NUM_CH * IN_DEPTH + OUT_DEPTH, held);
            end
            if (wr_ready !== '0) begin
               errors++;
               $display("[FAIL] %0t wr_ready expected 0 actual %h", $time, wr_ready);
            end
         end

         if (check_end) begin
            for (int c = 0; c < NUM_CH; c++) begin
               if (ref_q[c].size() != 0) begin
                  errors++;
                  $display("%0t: %0d words of channel %0d never came out",
                           $time, ref_q[c].size(), c);
               end
            end
         end
      end
   end

endmodule

// File: hdl/merge_top.sv
`timescale 1ns/10ps

module merge_top
   import merge_pkg::*;
#(
   parameter int IN_DEPTH  = 8,
   parameter int OUT_DEPTH = 16
) (
   input  logic                              clk,
   input  logic                              rst,

   // Producer side, channel 0 in the low slice
   input  logic [NUM_CH-1:0]                 wr_valid,
   output logic [NUM_CH-1:0]                 wr_ready,
   input  logic [NUM_CH*$bits(word_t)-1:0]   wr_data,

   // Consumer side
   input  logic                              read_valid,
   output logic                              read_ready,
   output tagged_t                           out_data
);

   logic [NUM_CH-1:0] pending;
   logic [NUM_CH-1:0] pop;
   word_t             ch_data [NUM_CH];

   logic              out_write;
   tagged_t           out_word;
   logic              out_write_ready;
   logic              out_almost_full;

   for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
      b_fifo #(
         .WIDTH ($bits(word_t)),
         .DEPTH (IN_DEPTH)
      ) u_ch_fifo (
         .clk         (clk),
         .rst         (rst),
         .read_valid  (pop[i]),
         .read_ready  (pending[i]),
         .write_valid (wr_valid[i]),
         .write_ready (wr_ready[i]),
         .almost_full (),             // Only the output FIFO needs it
         .in_data     (wr_data[i*$bits(word_t) +: $bits(word_t)]),
         .out_data    (ch_data[i])
      );
   end

   rr_arbiter u_arb (
      .clk             (clk),
      .rst             (rst),
      .pending         (pending),
      .ch_data         (ch_data),
      .pop             (pop),
      .out_write_ready (out_write_ready),
      .out_almost_full (out_almost_full),
      .out_write       (out_write),
      .out_word        (out_word)
   );

   b_fifo #(
      .WIDTH ($bits(tagged_t)),
      .DEPTH (OUT_DEPTH)
   ) u_out_fifo (
      .clk         (clk),
      .rst         (rst),
      .read_valid  (read_valid),
      .read_ready  (read_ready),
      .write_valid (out_write),
      .write_ready (out_write_ready),
      .almost_full (out_almost_full),
      .in_data     (out_word),
      .out_data    (out_data)
   );

endmodule

// File: hdl/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter
   import merge_pkg::*;
(
   input  logic              clk,
   input  logic              rst,

   input  logic [NUM_CH-1:0] pending,
   input  word_t             ch_data [NUM_CH],
   output logic [NUM_CH-1:0] pop,

   input  logic              out_write_ready,
   input  logic              out_almost_full,
   output logic              out_write,
   output tagged_t           out_word
);

   chan_t ptr;                       // First channel to look at
   chan_t grant_ch;
   logic  grant_ok;
   logic  room;
   logic  issue;

   logic  in_flight;                 // A popped word is on its way out
   chan_t in_ch;

   // First pending channel at or after the pointer
   always_comb begin
      chan_t cand;
      grant_ok = 1'b0;
      grant_ch = ptr;
      cand     = ptr;
      for (int i = NUM_CH - 1; i >= 0; i--) begin
         cand = ptr + chan_t'(i);
         if (pending[cand]) begin
            grant_ok = 1'b1;
            grant_ch = cand;
         end
      end
   end

   // At most two words may be in the pipeline toward the output FIFO
   assign room  = !out_almost_full || (out_write_ready && !in_flight);
   assign issue = grant_ok && room;

   always_comb begin
      pop = '0;
      if (issue) begin
         pop[grant_ch] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ptr       <= '0;
         in_flight <= 1'b0;
      end else begin
         in_flight <= issue;
         if (issue) begin
            ptr <= grant_ch + chan_t'(1);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         in_ch <= grant_ch;
      end
   end

   // Channel data is valid the cycle after its pop
   assign out_write = in_flight;
   assign out_word  = tag_word(in_ch, ch_data[in_ch]);

   a_pop_onehot: assert property (
      @(posedge clk) disable iff (rst)
      $onehot0(pop)
   ) else $error("rr_arbiter: more than one pop");

   a_pop_pending: assert property (
      @(posedge clk) disable iff (rst)
      (pop & ~pending) == '0
   ) else $error("rr_arbiter: pop on an empty channel");

   // Overrun rule keeps the output FIFO from ever refusing a write
   a_no_overrun: assert property (
      @(posedge clk) disable iff (rst)
      out_write |-> out_write_ready
   ) else $error("rr_arbiter: write into a full output FIFO");

endmodule

// File: hdl/b_fifo.sv
`timescale 1ns/10ps

module b_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic             clk,
   input  logic             rst,

   input  logic             read_valid,
   output logic             read_ready,

   input  logic             write_valid,
   output logic             write_ready,
   output logic             almost_full,

   input  logic [WIDTH-1:0] in_data,
   output logic [WIDTH-1:0] out_data
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] ram [DEPTH];

   logic [AW-1:0] write_addr;
   logic [AW-1:0] read_addr;
   logic [AW-1:0] next_write_addr;
   logic [AW-1:0] next_read_addr;

   logic          empty;
   logic          full;
   logic [CW-1:0] count;             // Words currently held

   // Addresses wrap at DEPTH, which need not be a power of two
   assign next_write_addr = (write_addr == AW'(DEPTH - 1)) ? '0 : write_addr + AW'(1);
   assign next_read_addr  = (read_addr == AW'(DEPTH - 1)) ? '0 : read_addr + AW'(1);

   assign full        = !empty && (write_addr == read_addr);
   assign write_ready = !full;
   assign read_ready  = !empty;
   assign almost_full = (count >= CW'(DEPTH - 1));

   always_ff @(posedge clk) begin
      if (write_valid) begin
         ram[write_addr] <= in_data;
      end
   end

   // Registered read port, holds the last popped word
   always_ff @(posedge clk) begin
      if (read_valid) begin
         out_data <= ram[read_addr];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         empty      <= 1'b1;
         write_addr <= '0;
         read_addr  <= '0;
      end else begin
         if (read_valid) begin
            read_addr <= next_read_addr;
            if ((next_read_addr == write_addr) && !write_valid) begin
               empty <= 1'b1;         // Last word leaves
            end
         end
         if (write_valid) begin
            write_addr <= next_write_addr;
            empty      <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
      end else begin
         case ({write_valid, read_valid})
            2'b10:   count <= count + CW'(1);
            2'b01:   count <= count - CW'(1);
            default: count <= count;  // Both or neither leave it unchanged
         endcase
      end
   end

   a_no_write_full: assert property (
      @(posedge clk) disable iff (rst)
      write_valid |-> !full
   ) else $error("b_fifo: write while full");

   a_no_read_empty: assert property (
      @(posedge clk) disable iff (rst)
      read_valid |-> !empty
   ) else $error("b_fifo: read while empty");

   // Counter and address flags must agree over time
   a_count_bound: assert property (
      @(posedge clk) disable iff (rst)
      (count <= CW'(DEPTH)) && (full == (count == CW'(DEPTH)))
   ) else $error("b_fifo: occupancy out of range");

endmodule

// File: hdl/merge_pkg.sv
package merge_pkg;

   // Number of producer channels; the tag width follows from it
   localparam int NUM_CH = 4;
   localparam int CH_W   = $clog2(NUM_CH);

   // Payload word as written by a producer
   typedef logic [31:0] word_t;

   // Channel number carried as the tag
   typedef logic [CH_W-1:0] chan_t;

   // Output word, tag in the top bits and payload below
   typedef logic [CH_W+$bits(word_t)-1:0] tagged_t;

   // Builds a tagged output word from a channel number and a payload
   function automatic tagged_t tag_word(input chan_t ch, input word_t w);
      tagged_t t;
      t = {ch, w};
      return t;
   endfunction

   // Channel number held in a tagged word
   function automatic chan_t tag_of(input tagged_t t);
      chan_t ch;
      ch = t[$bits(tagged_t)-1 -: CH_W];
      return ch;
   endfunction

endpackage
